/* rtl/a2600_pkg.sv */
//==================================================
// Shared types for the console front end
// Pad, mouse and paddle structs, option bits,
// bank scheme and mode enums, tuning constants
//==================================================

package a2600_pkg;

	// One player's controls from the host, active high
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire;
		logic fire2;
		logic stick_btn;
		logic paddle_btn;
		logic start;
		logic select;
		logic pause;
		logic sw_color;
		logic sw_diff1;
		logic sw_diff2;
	} pad_t;

	// Player controls toward the core, active low
	typedef struct packed {
		logic right;
		logic left;
		logic down;
		logic up;
		logic fire;
		logic fire2;
	} pad_out_t;

	// PS/2 style mouse packet with toggle strobe on top
	typedef struct packed {
		logic       strobe;
		logic [7:0] dy;
		logic [7:0] dx;
		logic [1:0] ovf;
		logic       y_sign;
		logic       x_sign;
		logic [1:0] rsvd;
		logic [1:0] btn;
	} mouse_t;

	typedef struct packed {
		logic       b;
		logic [7:0] a;
	} paddle_t;

	typedef struct packed {
		logic mono;
		logic diff_p1;
		logic diff_p2;
	} options_t;

	typedef enum logic [3:0] {
		BS_NONE = 4'd0,  BS_F8 = 4'd1,  BS_F6 = 4'd2,   BS_FE = 4'd3,
		BS_E0 = 4'd4,    BS_E3F = 4'd5, BS_F4 = 4'd6,   BS_P2 = 4'd7,
		BS_FA = 4'd8,    BS_CV = 4'd9,  BS_UA = 4'd11,  BS_E7 = 4'd12,
		BS_F0 = 4'd13,   BS_X32 = 4'd14
	} bank_scheme_t;

	typedef enum logic [1:0] {SC_AUTO = 2'd0, SC_DISABLE = 2'd1, SC_ENABLE = 2'd2} sc_mode_t;
	typedef enum logic [1:0] {AR_ADAPTIVE = 2'd0, AR_FIXED = 2'd1, AR_WIDE = 2'd2} aspect_mode_t;
	typedef enum logic [1:0] {SRC_PADDLE = 2'd0, SRC_STICK = 2'd1, SRC_MOUSE = 2'd2} paddle_src_t;

	// Paddle tuning
	localparam int STICK_THRESH   = 100;
	localparam int MOUSE_STEP_MAX = 10;

	// Blanking regeneration, in lines
	localparam int VBL_END_LINE = 34;
	localparam int VBL_LEAD     = 25;

	// Aspect ratio values
	localparam int ARX_NARROW = 154;
	localparam int ARY_FIXED  = 108;
	localparam int ARX_WIDE   = 16;
	localparam int ARY_WIDE   = 9;

endpackage

/* rtl/console_ctl.sv */
//==================================================
// Console controls: player swap, start/select,
// switch option toggles and the pause toggle
//==================================================

`timescale 1ns/1ps

module console_ctl (
	input  logic                clk_sys,
	input  logic                reset,
	input  logic                swap,
	input  a2600_pkg::pad_t     pad_0,
	input  a2600_pkg::pad_t     pad_1,
	output a2600_pkg::pad_out_t p1,
	output a2600_pkg::pad_out_t p2,
	output a2600_pkg::pad_t     pad_a,
	output a2600_pkg::pad_t     pad_b,
	output logic                start_n,
	output logic                select_n,
	output a2600_pkg::options_t options,
	output logic                pause
);
	import a2600_pkg::*;

	logic [2:0] sw_now;
	logic [2:0] sw_prev;
	logic [2:0] sw_rise;
	logic       pause_req;
	logic       pause_s1;
	logic       pause_s2;

	// Core pins are active low
	function automatic pad_out_t to_core(input pad_t pad);
		pad_out_t res;
		res.right = ~pad.right;
		res.left  = ~pad.left;
		res.down  = ~pad.down;
		res.up    = ~pad.up;
		res.fire  = ~pad.fire;
		res.fire2 = ~pad.fire2;
		return res;
	endfunction

	//==================================================
	// Player swap
	//==================================================
	assign pad_a = swap ? pad_1 : pad_0;
	assign pad_b = swap ? pad_0 : pad_1;

	assign p1 = to_core(pad_a);
	assign p2 = to_core(pad_b);

	// Either player may press start or select
	assign start_n  = ~(pad_0.start | pad_1.start);
	assign select_n = ~(pad_0.select | pad_1.select);

	//==================================================
	// Option toggles
	//==================================================
	assign sw_now = {pad_0.sw_color | pad_1.sw_color,
			 pad_0.sw_diff1 | pad_1.sw_diff1,
			 pad_0.sw_diff2 | pad_1.sw_diff2};

	// Edge is latched first, the option flips one clock later
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sw_prev <= '0;
			sw_rise <= '0;
			options <= '0;
		end else begin
			sw_prev <= sw_now;
			sw_rise <= sw_now & ~sw_prev;
			options <= options_t'(options ^ sw_rise);
		end
	end

	//==================================================
	// Pause
	//==================================================
	assign pause_req = pad_0.pause | pad_1.pause;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			pause_s1 <= 1'b0;
			pause_s2 <= 1'b0;
			pause    <= 1'b0;
		end else begin
			pause_s1 <= pause_req;
			pause_s2 <= pause_s1;
			if (pause_s1 && !pause_s2)
				pause <= ~pause;
		end
	end

endmodule

/* rtl/paddle_ctl.sv */
//==================================================
// Paddle controller
// Source select between paddle, stick and mouse,
// mouse delta clamp and saturating accumulation
//==================================================

`timescale 1ns/1ps

module paddle_ctl (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              invert,
	input  a2600_pkg::pad_t   pad,
	input  logic [15:0]       joy_a,
	input  logic [7:0]        paddle_in,
	input  a2600_pkg::mouse_t mouse,
	output a2600_pkg::paddle_t out
);
	import a2600_pkg::*;

	paddle_src_t       src;
	logic              use_y;
	logic              stb_prev;
	logic signed [7:0] mx;
	logic signed [7:0] my;
	logic [7:0]        pos;

	// Clamp one delta to the step limit and add it with saturation
	function automatic logic signed [7:0] step_acc(
		input logic signed [7:0] acc,
		input logic              sgn,
		input logic [7:0]        mag
	);
		logic signed [8:0] delta;
		logic signed [9:0] sum;
		delta = {sgn, mag};
		if (delta > MOUSE_STEP_MAX)
			delta = 9'(MOUSE_STEP_MAX);
		else if (delta < -MOUSE_STEP_MAX)
			delta = -9'(MOUSE_STEP_MAX);
		sum = acc + delta;
		if (sum > 127)
			return 8'sd127;
		else if (sum < -128)
			return -8'sd128;
		return sum[7:0];
	endfunction

	//==================================================
	// Source and axis selection
	//==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			src      <= SRC_PADDLE;
			use_y    <= 1'b0;
			stb_prev <= 1'b0;
			mx       <= '0;
			my       <= '0;
		end else begin
			stb_prev <= mouse.strobe;
			// New mouse packet
			if (mouse.strobe != stb_prev) begin
				src <= SRC_MOUSE;
				mx  <= step_acc(mx, mouse.x_sign, mouse.dx);
				my  <= step_acc(my, mouse.y_sign, mouse.dy);
			end
			// Later assignments win, so paddle beats stick beats mouse
			if (pad.stick_btn)
				src <= SRC_STICK;
			if (pad.paddle_btn)
				src <= SRC_PADDLE;

			if (src == SRC_MOUSE) begin
				if (mouse.btn[1])
					use_y <= 1'b1;
				if (mouse.btn[0])
					use_y <= 1'b0;
			end else if (src == SRC_STICK) begin
				if (!joy_a[15] && joy_a[15:8] > STICK_THRESH)
					use_y <= 1'b1;
				if (!joy_a[7] && joy_a[7:0] > STICK_THRESH)
					use_y <= 1'b0;
			end
		end
	end

	//==================================================
	// Output stage
	//==================================================
	always_comb begin
		case (src)
			SRC_STICK: pos = use_y ? joy_a[15:8] : joy_a[7:0];
			SRC_MOUSE: pos = use_y ? my : mx;
			default:   pos = {~paddle_in[7], paddle_in[6:0]};
		endcase
	end

	always_ff @(posedge clk_sys) begin
		out.a <= invert ? ~pos : pos;
		case (src)
			SRC_STICK: out.b <= pad.stick_btn;
			SRC_MOUSE: out.b <= |mouse.btn;
			default:   out.b <= pad.paddle_btn;
		endcase
	end

endmodule

/* rtl/cart_detect.sv */
//==================================================
// Cartridge detection at download start
// Extension to bank scheme, SuperChip RAM flag
//==================================================

`timescale 1ns/1ps

module cart_detect (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    download,
	input  logic [31:0]             file_ext,
	input  a2600_pkg::sc_mode_t     sc_mode,
	output a2600_pkg::bank_scheme_t force_bs,
	output logic                    sc
);
	import a2600_pkg::*;

	logic [23:0]  ext;
	logic         dl_prev;
	bank_scheme_t scheme;
	logic         sc_next;

	// Short names put the dot in byte 2, long ones end with a suffix letter
	assign ext = (file_ext[23:16] == ".") ? file_ext[23:0] : file_ext[31:8];

	always_comb begin
		case (ext)
			".F8":   scheme = BS_F8;
			".F6":   scheme = BS_F6;
			".FE":   scheme = BS_FE;
			".E0":   scheme = BS_E0;
			".3F":   scheme = BS_E3F;
			".F4":   scheme = BS_F4;
			".P2":   scheme = BS_P2;
			".FA":   scheme = BS_FA;
			".CV":   scheme = BS_CV;
			".UA":   scheme = BS_UA;
			".E7":   scheme = BS_E7;
			".F0":   scheme = BS_F0;
			".32":   scheme = BS_X32;
			default: scheme = BS_NONE;
		endcase
	end

	// Auto mode looks for a trailing S in the extension
	assign sc_next = (sc_mode == SC_AUTO) ? (file_ext[7:0] == "S") : (sc_mode == SC_ENABLE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_prev  <= 1'b0;
			force_bs <= BS_NONE;
			sc       <= 1'b0;
		end else begin
			dl_prev <= download;
			if (download && !dl_prev) begin
				force_bs <= scheme;
				sc       <= sc_next;
			end
		end
	end

endmodule

/* rtl/frame_monitor.sv */
//==================================================
// Frame monitor
// Line counting, vblank regeneration and the
// adaptive vertical aspect value
//==================================================

`timescale 1ns/1ps

module frame_monitor #(
	parameter int LINE_W = 9
) (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    hs,
	input  logic                    vs,
	input  logic                    vb_core,
	input  logic                    vblank_original,
	input  a2600_pkg::aspect_mode_t aspect_mode,
	output logic                    vblank,
	output logic [7:0]              video_arx,
	output logic [7:0]              video_ary
);
	import a2600_pkg::*;

	logic              hs_prev;
	logic              vs_prev;
	logic              line_ev;
	logic [LINE_W-1:0] line_cnt;
	logic [LINE_W-1:0] vis_cnt;
	logic [LINE_W-1:0] vbl_start;
	logic              vbl_gen;
	logic [7:0]        ary_adapt;
	logic [7:0]        vis_sat;
	logic [11:0]       ary_scaled;

	assign line_ev = hs && !hs_prev;
	assign vblank  = vblank_original ? vb_core : vbl_gen;

	// Visible lines times 9/16, rounded half up
	assign vis_sat    = (vis_cnt >= 255) ? 8'hff : vis_cnt[7:0];
	assign ary_scaled = 12'(vis_sat) * 12'd9 + 12'd8;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			hs_prev   <= 1'b0;
			vs_prev   <= 1'b0;
			line_cnt  <= '0;
			vis_cnt   <= '0;
			vbl_start <= '0;
			vbl_gen   <= 1'b0;
			ary_adapt <= 8'(ARY_FIXED);
		end else begin
			hs_prev <= hs;
			if (line_ev) begin
				vs_prev  <= vs;
				line_cnt <= line_cnt + 1'b1;
				if (!vblank)
					vis_cnt <= vis_cnt + 1'b1;
				// Frame start
				if (vs && !vs_prev) begin
					line_cnt  <= '0;
					vis_cnt   <= '0;
					vbl_start <= line_cnt - LINE_W'(VBL_LEAD);
					ary_adapt <= ary_scaled[11:4];
				end
				if (line_cnt == vbl_start)
					vbl_gen <= 1'b1;
				if (line_cnt == LINE_W'(VBL_END_LINE))
					vbl_gen <= 1'b0;
			end
		end
	end

	//==================================================
	// Aspect outputs
	//==================================================
	always_comb begin
		case (aspect_mode)
			AR_WIDE: begin
				video_arx = 8'(ARX_WIDE);
				video_ary = 8'(ARY_WIDE);
			end
			AR_FIXED: begin
				video_arx = 8'(ARX_NARROW);
				video_ary = 8'(ARY_FIXED);
			end
			default: begin
				video_arx = 8'(ARX_NARROW);
				video_ary = ary_adapt;
			end
		endcase
	end

endmodule

/* rtl/a2600_front.sv */
//==================================================
// Console front end top level
// Controls, paddles, cartridge scheme, frame timing
//==================================================

`timescale 1ns/1ps

module a2600_front #(
	parameter int LINE_W = 9
) (
	input  logic                    clk_sys,
	input  logic                    reset,

	input  a2600_pkg::pad_t         pad_0,
	input  a2600_pkg::pad_t         pad_1,
	input  a2600_pkg::mouse_t       mouse,
	input  logic [15:0]             joya_0,
	input  logic [15:0]             joya_1,
	input  logic [7:0]              pd_0,
	input  logic [7:0]              pd_1,

	input  logic                    swap,
	input  logic                    invert_paddle,
	input  a2600_pkg::sc_mode_t     sc_mode,
	input  a2600_pkg::aspect_mode_t aspect_mode,
	input  logic                    vblank_original,

	input  logic                    download,
	input  logic [31:0]             file_ext,

	input  logic                    hs,
	input  logic                    vs,
	input  logic                    vb_core,

	output a2600_pkg::pad_out_t     p1,
	output a2600_pkg::pad_out_t     p2,
	output a2600_pkg::paddle_t      paddle_1,
	output a2600_pkg::paddle_t      paddle_2,
	output logic                    start_n,
	output logic                    select_n,
	output a2600_pkg::options_t     options,
	output logic                    pause,
	output a2600_pkg::bank_scheme_t force_bs,
	output logic                    sc,
	output logic                    vblank,
	output logic [7:0]              video_arx,
	output logic [7:0]              video_ary
);
	import a2600_pkg::*;

	// Pads after the player swap, toward the paddles
	pad_t pad_a;
	pad_t pad_b;

	console_ctl u_console (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.swap     (swap),
		.pad_0    (pad_0),
		.pad_1    (pad_1),
		.p1       (p1),
		.p2       (p2),
		.pad_a    (pad_a),
		.pad_b    (pad_b),
		.start_n  (start_n),
		.select_n (select_n),
		.options  (options),
		.pause    (pause)
	);

	// Only the first paddle listens to the mouse
	paddle_ctl u_paddle_1 (
		.clk_sys (clk_sys), .reset (reset), .invert (invert_paddle),
		.pad (pad_a), .joy_a (joya_0), .paddle_in (pd_0), .mouse (mouse),
		.out (paddle_1)
	);

	paddle_ctl u_paddle_2 (
		.clk_sys (clk_sys), .reset (reset), .invert (invert_paddle),
		.pad (pad_b), .joy_a (joya_1), .paddle_in (pd_1), .mouse ('0),
		.out (paddle_2)
	);

	cart_detect u_cart (
		.clk_sys (clk_sys), .reset (reset), .download (download),
		.file_ext (file_ext), .sc_mode (sc_mode),
		.force_bs (force_bs), .sc (sc)
	);

	frame_monitor #(.LINE_W(LINE_W)) u_frame (
		.clk_sys (clk_sys), .reset (reset),
		.hs (hs), .vs (vs), .vb_core (vb_core),
		.vblank_original (vblank_original), .aspect_mode (aspect_mode),
		.vblank (vblank), .video_arx (video_arx), .video_ary (video_ary)
	);

endmodule

/* testbench/tb_clock_gen.sv */
//==================================================
// Testbench clock and power-on reset source
//==================================================

`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 2
) (
	output logic clk_sys,
	output logic por
);
	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
	end

	// Release on a falling edge, away from the sampling edge
	initial begin
		por = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		por = 1'b0;
	end

endmodule

/* testbench/tb_a2600_front.sv */
//==================================================
// Testbench for the console front end
// Stimulus table, row loop, reference models,
// value check and cycle timeout
//==================================================

`timescale 1ns/1ps

module tb_a2600_front;
	import a2600_pkg::*;

	typedef enum logic [3:0] {
		OP_CART, OP_SW, OP_PAUSE, OP_RESET, OP_PADS,
		OP_PADDLE, OP_STICK, OP_MOUSE, OP_FRAME
	} op_e;

	typedef struct packed {
		op_e         op;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] exp;
	} row_t;

	logic clk_sys, por, rst_req, reset;
	pad_t pad_0, pad_1;
	mouse_t mouse;
	logic [15:0] joya_0, joya_1;
	logic [7:0] pd_0, pd_1;
	logic swap, invert_paddle, vblank_original, download, hs, vs, vb_core;
	sc_mode_t sc_mode;
	aspect_mode_t aspect_mode;
	logic [31:0] file_ext;
	pad_out_t p1, p2;
	paddle_t paddle_1, paddle_2;
	logic start_n, select_n, pause, sc, vblank;
	options_t options;
	bank_scheme_t force_bs;
	logic [7:0] video_arx, video_ary;

	row_t rows[$];
	int cycles = 0;
	int limit = 0;
	// Mouse accumulators predicted by the model
	int acc_x = 0;
	int acc_y = 0;

	logic [23:0] ext_list [13] = '{".F8", ".F6", ".FE", ".E0", ".3F", ".F4", ".P2",
		".FA", ".CV", ".UA", ".E7", ".F0", ".32"};
	logic [3:0] bs_list [13] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 11, 12, 13, 14};

	assign reset = por | rst_req;

	tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(2)) u_clk (.clk_sys(clk_sys), .por(por));

	a2600_front #(.LINE_W(9)) u_dut (
		.clk_sys(clk_sys), .reset(reset), .pad_0(pad_0), .pad_1(pad_1), .mouse(mouse),
		.joya_0(joya_0), .joya_1(joya_1), .pd_0(pd_0), .pd_1(pd_1), .swap(swap),
		.invert_paddle(invert_paddle), .sc_mode(sc_mode), .aspect_mode(aspect_mode),
		.vblank_original(vblank_original), .download(download), .file_ext(file_ext),
		.hs(hs), .vs(vs), .vb_core(vb_core), .p1(p1), .p2(p2), .paddle_1(paddle_1),
		.paddle_2(paddle_2), .start_n(start_n), .select_n(select_n), .options(options),
		.pause(pause), .force_bs(force_bs), .sc(sc), .vblank(vblank),
		.video_arx(video_arx), .video_ary(video_ary)
	);

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s got %0h expected %0h", $time, what, got, exp);
			$display("sim failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic add_row(input op_e op, input int a, input int b, input int c, input int exp);
		row_t r;
		r.op = op;
		r.a = a;
		r.b = b;
		r.c = c;
		r.exp = exp;
		rows.push_back(r);
	endtask

	function automatic int row_cycles(input row_t r);
		case (r.op)
			OP_CART:  return 6;
			OP_RESET: return 7;
			OP_MOUSE: return 5 + 2 * r.c;
			OP_FRAME: return 5 + 3 * (2 * r.a + 2);
			default:  return 5;
		endcase
	endfunction

	// Signed delta from sign and magnitude, clamped, added with saturation
	function automatic int mouse_step(input int acc, input logic sgn, input logic [7:0] mag);
		int d;
		d = sgn ? int'(mag) - 256 : int'(mag);
		if (d > 10)
			d = 10;
		if (d < -10)
			d = -10;
		acc = acc + d;
		if (acc > 127)
			acc = 127;
		if (acc < -128)
			acc = -128;
		return acc;
	endfunction

	function automatic logic [8:0] paddle_exp(input logic [7:0] pd, input logic inv);
		return {1'b1, {~pd[7], pd[6:0]} ^ {8{inv}}};
	endfunction

	//==================================================
	// Row execution
	//==================================================
	task automatic run_frames(input row_t r);
		int n;
		n = r.a;
		vblank_original = r.c[2];
		aspect_mode = aspect_mode_t'(r.c[1:0]);
		// One line with vs low so the first frame opens on a vs rise
		@(negedge clk_sys);
		hs = 1'b1;
		vs = 1'b0;
		vb_core = 1'b1;
		@(negedge clk_sys);
		hs = 1'b0;
		@(negedge clk_sys);
		for (int f = 0; f < 3; f++) begin
			for (int k = 0; k < ((f == 2) ? 1 : n); k++) begin
				@(negedge clk_sys);
				hs = 1'b1;
				vs = (k == 0);
				vb_core = (k < n - int'(r.b));
				@(negedge clk_sys);
				// Regenerated blank in the second frame, after the clear line
				if (r.c[3] && f == 1 && k >= 35)
					check(vblank, (k >= n - 25), "vblank");
				hs = 1'b0;
				@(negedge clk_sys);
			end
		end
		vs = 1'b0;
	endtask

	task automatic apply_row(input row_t r);
		logic [31:0] got;
		logic [31:0] exp;
		logic [7:0] v;
		exp = r.exp;
		@(negedge clk_sys);
		case (r.op)
			OP_CART: begin
				download = 1'b0;
				file_ext = r.a;
				sc_mode = sc_mode_t'(r.b[1:0]);
				@(negedge clk_sys);
				download = 1'b1;
			end
			OP_SW, OP_PAUSE, OP_PADS: begin
				pad_0 = '0;
				pad_1 = '0;
				swap = 1'b0;
				if (r.op == OP_SW) begin
					{pad_0.sw_color, pad_0.sw_diff1, pad_0.sw_diff2} = r.a[2:0];
					{pad_1.sw_color, pad_1.sw_diff1, pad_1.sw_diff2} = r.b[2:0];
				end else if (r.op == OP_PAUSE) begin
					pad_0.pause = r.a[0];
					pad_1.pause = r.b[0];
				end else begin
					{pad_0.right, pad_0.left, pad_0.down, pad_0.up,
						pad_0.fire, pad_0.fire2} = r.a[5:0];
					{pad_1.right, pad_1.left, pad_1.down, pad_1.up,
						pad_1.fire, pad_1.fire2} = r.b[5:0];
					pad_0.start = r.a[6];
					pad_0.select = r.a[7];
					pad_1.start = r.b[6];
					pad_1.select = r.b[7];
					swap = r.a[8];
				end
			end
			OP_RESET: begin
				pad_0 = '0;
				pad_1 = '0;
				rst_req = 1'b1;
				repeat (2) @(negedge clk_sys);
				rst_req = 1'b0;
				acc_x = 0;
				acc_y = 0;
			end
			OP_PADDLE: begin
				pad_0 = '0;
				pad_1 = '0;
				swap = 1'b0;
				pad_0.paddle_btn = 1'b1;
				pad_1.paddle_btn = 1'b1;
				invert_paddle = r.b[0];
				pd_0 = $urandom;
				pd_1 = $urandom;
				exp = {paddle_exp(pd_1, r.b[0]), paddle_exp(pd_0, r.b[0])};
			end
			OP_STICK: begin
				pad_0.paddle_btn = 1'b0;
				pad_0.stick_btn = 1'b1;
				invert_paddle = r.b[0];
				v = 8'(101 + $urandom % 27);
				// The other axis is negative, so only one axis qualifies
				joya_0 = r.a[0] ? {v, 8'h80 | 8'($urandom)} : {8'h80 | 8'($urandom), v};
				exp = {1'b1, v ^ {8{r.b[0]}}};
			end
			OP_MOUSE: begin
				pad_0.paddle_btn = 1'b0;
				pad_0.stick_btn = 1'b0;
				invert_paddle = r.b[0];
				mouse.btn = r.b[1] ? 2'b10 : 2'b01;
				for (int i = 0; i < r.c; i++) begin
					mouse.strobe = ~mouse.strobe;
					mouse.dx = r.b[2] ? 8'h40 : 8'($urandom);
					mouse.dy = r.b[2] ? 8'h40 : 8'($urandom);
					mouse.x_sign = r.b[2] ? 1'b0 : 1'($urandom);
					mouse.y_sign = r.b[2] ? 1'b0 : 1'($urandom);
					acc_x = mouse_step(acc_x, mouse.x_sign, mouse.dx);
					acc_y = mouse_step(acc_y, mouse.y_sign, mouse.dy);
					repeat (2) @(negedge clk_sys);
				end
				v = r.b[1] ? 8'(acc_y) : 8'(acc_x);
				exp = {1'b1, v ^ {8{r.b[0]}}};
			end
			default: run_frames(r);
		endcase
		repeat (4) @(negedge clk_sys);
		case (r.op)
			OP_CART:   got = {sc, force_bs};
			OP_SW:     got = options;
			OP_PAUSE:  got = pause;
			OP_RESET:  got = {pause, options};
			OP_PADS:   got = {start_n, select_n, p1, p2};
			OP_PADDLE: got = {paddle_2, paddle_1};
			OP_STICK, OP_MOUSE: got = paddle_1;
			default:   got = {video_arx, video_ary};
		endcase
		check(got, exp, r.op.name());
	endtask

	//==================================================
	// Stimulus table and main loop
	//==================================================
	initial begin
		void'($urandom(51));
		pad_0 = '0;
		pad_1 = '0;
		mouse = '0;
		{joya_0, joya_1, pd_0, pd_1} = '0;
		{swap, invert_paddle, download, hs, vs, vb_core, rst_req} = '0;
		vblank_original = 1'b1;
		sc_mode = SC_AUTO;
		aspect_mode = AR_ADAPTIVE;
		file_ext = '0;

		// Each extension dot first and then dot last with a trailing S
		for (int i = 0; i < 13; i++) begin
			add_row(OP_CART, {8'h00, ext_list[i]}, SC_AUTO, 0, {1'b0, bs_list[i]});
			add_row(OP_CART, {ext_list[i], "S"}, SC_AUTO, 0, {1'b1, bs_list[i]});
		end
		add_row(OP_CART, {8'h00, ".ZZ"}, SC_AUTO, 0, 5'h00);
		add_row(OP_CART, ".BIN", SC_AUTO, 0, 5'h00);
		add_row(OP_CART, {".F8", "S"}, SC_DISABLE, 0, 5'h01);
		add_row(OP_CART, {8'h00, ".F6"}, SC_ENABLE, 0, 5'h12);
		// Switch presses, holds and releases
		add_row(OP_SW, 3'b100, 0, 0, 3'b100);
		add_row(OP_SW, 3'b100, 0, 0, 3'b100);
		add_row(OP_SW, 0, 0, 0, 3'b100);
		add_row(OP_SW, 0, 3'b010, 0, 3'b110);
		add_row(OP_SW, 0, 0, 0, 3'b110);
		add_row(OP_SW, 3'b001, 0, 0, 3'b111);
		add_row(OP_SW, 0, 0, 0, 3'b111);
		add_row(OP_SW, 0, 3'b100, 0, 3'b011);
		add_row(OP_PAUSE, 1, 0, 0, 1);
		add_row(OP_PAUSE, 1, 0, 0, 1);
		add_row(OP_PAUSE, 0, 0, 0, 1);
		add_row(OP_PAUSE, 0, 1, 0, 0);
		add_row(OP_PAUSE, 0, 0, 0, 0);
		add_row(OP_PAUSE, 1, 0, 0, 1);
		add_row(OP_RESET, 0, 0, 0, 0);
		// Pads with swap off, swap on, then start and select
		add_row(OP_PADS, 9'h029, 8'h16, 0, {2'b11, 6'b010110, 6'b101001});
		add_row(OP_PADS, 9'h129, 8'h16, 0, {2'b11, 6'b101001, 6'b010110});
		add_row(OP_PADS, 9'h080, 8'h40, 0, {2'b00, 12'hfff});
		add_row(OP_PADS, 9'h100, 8'h80, 0, {2'b10, 12'hfff});
		// Paddle sources, expected values come from the models
		add_row(OP_PADDLE, 0, 0, 0, 0);
		add_row(OP_STICK, 1, 0, 0, 0);
		add_row(OP_STICK, 0, 1, 0, 0);
		add_row(OP_MOUSE, 0, 3'b000, 6, 0);
		add_row(OP_MOUSE, 0, 3'b010, 6, 0);
		add_row(OP_MOUSE, 0, 3'b101, 30, 0);
		add_row(OP_PADDLE, 0, 1, 0, 0);
		// Frame rows hold lines, visible lines and {check vblank, original, aspect}
		add_row(OP_FRAME, 262, 200, 4'b0100, {8'd154, 8'd113});
		add_row(OP_FRAME, 320, 300, 4'b0100, {8'd154, 8'd143});
		add_row(OP_FRAME, 262, 192, 4'b1001, {8'd154, 8'd108});
		add_row(OP_FRAME, 262, 192, 4'b0110, {8'd16, 8'd9});

		for (int i = 0; i < rows.size(); i++)
			limit += row_cycles(rows[i]);
		limit = 2 * limit + 20;

		while (por)
			@(negedge clk_sys);
		for (int i = 0; i < rows.size(); i++)
			apply_row(rows[i]);
		$display("sim passed");
		$finish;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("Timeout: the run went past %0d clock cycles", limit);
			$display("sim failed");
			$fatal(1, "timeout");
		end
	end

endmodule

/* compile.f */
rtl/a2600_pkg.sv
rtl/console_ctl.sv
rtl/paddle_ctl.sv
rtl/cart_detect.sv
rtl/frame_monitor.sv
rtl/a2600_front.sv
testbench/tb_clock_gen.sv
testbench/tb_a2600_front.sv
